// File: mailbox.f
common/mbox_pkg.sv
common/fifo_if.sv
fifo/fifo_ctrl.sv
fifo/fifo_small.sv
src/mbox_decode.sv
src/mbox_result.sv
src/mbox_top.sv
sim/mbox_tb.sv

// File: sim/mbox_tb.sv
// Mailbox testbench driving Wishbone cycles from a table and a random push/pop phase
`default_nettype none

module mbox_tb
    import mbox_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH   = 4;
    localparam int ACK_MAX = 20;

    typedef enum logic {KIND_DATA, KIND_STATUS} kind_t;

    logic  clk = 1'b0;
    logic  rst;
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat_w;
    data_t dat_r;
    logic  ack;

    // Stimulus table, one entry per bus cycle
    string row_name[$];
    logic  row_we[$];
    addr_t row_adr[$];
    data_t row_dat[$];
    kind_t row_kind[$];
    data_t row_exp[$];

    mbox_top #(
        .DEPTH ( DEPTH )
    ) dut_i (
        .clk   ( clk ),
        .rst   ( rst ),
        .cyc   ( cyc ),
        .stb   ( stb ),
        .we    ( we ),
        .adr   ( adr ),
        .dat_w ( dat_w ),
        .dat_r ( dat_r ),
        .ack   ( ack )
    );

    // 20 ns period
    always #10 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected status word assembled from the field layout
    function automatic data_t make_status(input logic empty, input logic full,
                                          input logic oflow, input logic uflow,
                                          input int cnt);
        data_t w;
        w = '0;
        w[STAT_EMPTY_BIT] = empty;
        w[STAT_FULL_BIT]  = full;
        w[STAT_OFLOW_BIT] = oflow;
        w[STAT_UFLOW_BIT] = uflow;
        w[STAT_COUNT_LSB +: STAT_COUNT_W] = STAT_COUNT_W'(cnt);
        return w;
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    // Field by field, unused bits must stay zero
    task automatic check_status(input string name, input data_t exp, input data_t act);
        logic bad;
        bad = (act[STAT_EMPTY_BIT] !== exp[STAT_EMPTY_BIT])
           || (act[STAT_FULL_BIT]  !== exp[STAT_FULL_BIT])
           || (act[STAT_OFLOW_BIT] !== exp[STAT_OFLOW_BIT])
           || (act[STAT_UFLOW_BIT] !== exp[STAT_UFLOW_BIT])
           || (act[STAT_COUNT_LSB +: STAT_COUNT_W] !== exp[STAT_COUNT_LSB +: STAT_COUNT_W])
           || (act !== exp);
        if (bad)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    // --------------------------------------------------
    // Bus cycle
    // --------------------------------------------------
    // New request goes out one clock after the previous ack, so calls run back to back
    task automatic bus_cycle(input logic w, input addr_t a, input data_t d,
                             output data_t r);
        int waited;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= w;
        adr   <= a;
        dat_w <= d;
        waited = 0;
        // Sample ack and dat_r mid-cycle
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_MAX)
                abort_run("Bus cycle timed out, ack never arrived");
        end while (!ack);
        // Ack due one clock after the request, seen at the second negedge
        if (waited != 2)
            abort_run("Ack did not arrive exactly one clock after the request");
        r = dat_r;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic add_row(input string name, input logic w, input addr_t a,
                           input data_t d, input kind_t k, input data_t exp);
        row_name.push_back(name);
        row_we.push_back(w);
        row_adr.push_back(a);
        row_dat.push_back(d);
        row_kind.push_back(k);
        row_exp.push_back(exp);
    endtask

    // --------------------------------------------------
    // Table, values for DEPTH 4
    // --------------------------------------------------
    // Write rows carry no expected value
    task automatic build_table();
        add_row("reset_status", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(1, 0, 0, 0, 0));
        add_row("push_a", 1, ADDR_DATA, 16'h1111, KIND_DATA, 0);
        add_row("stat_one", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(0, 0, 0, 0, 1));
        add_row("push_b", 1, ADDR_DATA, 16'h2222, KIND_DATA, 0);
        add_row("stat_two", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(0, 0, 0, 0, 2));
        add_row("pop_a", 0, ADDR_DATA, 0, KIND_DATA, 16'h1111);
        add_row("stat_after_pop", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(0, 0, 0, 0, 1));
        add_row("pop_b", 0, ADDR_DATA, 0, KIND_DATA, 16'h2222);
        add_row("stat_drain", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(1, 0, 0, 0, 0));
        // Fill, then push into a full FIFO
        for (int i = 1; i <= DEPTH; i++)
            add_row($sformatf("fill_%0d", i), 1, ADDR_DATA, 16'hA000 + i, KIND_DATA, 0);
        add_row("stat_full", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(0, 1, 0, 0, 4));
        add_row("push_drop", 1, ADDR_DATA, 16'hDEAD, KIND_DATA, 0);
        add_row("stat_oflow", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(0, 1, 1, 0, 4));
        add_row("stat_oflow_clr", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(0, 1, 0, 0, 4));
        for (int i = 1; i <= DEPTH; i++)
            add_row($sformatf("unfill_%0d", i), 0, ADDR_DATA, 0, KIND_DATA, 16'hA000 + i);
        add_row("stat_empty", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(1, 0, 0, 0, 0));
        // Pop while empty
        add_row("pop_empty", 0, ADDR_DATA, 0, KIND_DATA, 16'h0000);
        add_row("stat_uflow", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(1, 0, 0, 1, 0));
        add_row("stat_uflow_clr", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(1, 0, 0, 0, 0));
        // Push with a pop right behind it
        add_row("b2b_push", 1, ADDR_DATA, 16'h5A5A, KIND_DATA, 0);
        add_row("b2b_pop", 0, ADDR_DATA, 0, KIND_DATA, 16'h5A5A);
        add_row("stat_end", 0, ADDR_STATUS, 0, KIND_STATUS, make_status(1, 0, 0, 0, 0));
    endtask

    task automatic run_table();
        data_t r;
        foreach (row_name[i]) begin
            bus_cycle(row_we[i], row_adr[i], row_dat[i], r);
            if (!row_we[i]) begin
                if (row_kind[i] == KIND_STATUS)
                    check_status(row_name[i], row_exp[i], r);
                else
                    check_data(row_name[i], row_exp[i], r);
            end
        end
    endtask

    // --------------------------------------------------
    // Random phase against a reference queue
    // --------------------------------------------------
    // Starts from an empty FIFO with clear sticky flags
    task automatic run_random();
        logic [31:0] state;
        data_t       model_q[$];
        logic        model_oflow;
        logic        model_uflow;
        data_t       r;
        data_t       exp;
        string       name;
        state       = 32'd3781;
        model_oflow = 1'b0;
        model_uflow = 1'b0;
        for (int i = 0; i < 40; i++) begin
            state = xorshift(state);
            name  = $sformatf("rand_%0d", i);
            if (state[0]) begin
                bus_cycle(1'b1, ADDR_DATA, state[31:16], r);
                if (model_q.size() == DEPTH)
                    model_oflow = 1'b1;
                else
                    model_q.push_back(state[31:16]);
            end else begin
                bus_cycle(1'b0, ADDR_DATA, '0, r);
                if (model_q.size() == 0) begin
                    exp         = '0;
                    model_uflow = 1'b1;
                end else begin
                    exp = model_q.pop_front();
                end
                check_data(name, exp, r);
            end
            // Status after every op, which also clears the sticky flags
            bus_cycle(1'b0, ADDR_STATUS, '0, r);
            exp = make_status(model_q.size() == 0, model_q.size() == DEPTH,
                              model_oflow, model_uflow, model_q.size());
            check_status({name, "_status"}, exp, r);
            model_oflow = 1'b0;
            model_uflow = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = ADDR_DATA;
        dat_w = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        build_table();
        run_table();
        bus_idle();
        run_random();
        bus_idle();
        $display("All tests passed!");
        $finish;
    end

endmodule : mbox_tb

`default_nettype wire

// File: src/mbox_top.sv
// Mailbox top level joining bus decode, FIFO and read result behind Wishbone ports
`default_nettype none

module mbox_top
    import mbox_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,

    // Wishbone classic slave
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  addr_t adr,
    input  data_t dat_w,
    output data_t dat_r,
    output logic  ack
);
    // Internal FIFO bus
    fifo_if #(.DEPTH(DEPTH)) fifo_bus (.clk(clk), .rst(rst));

    logic status_rd;

    // Decode
    mbox_decode i_mbox_decode (
        .clk       ( clk ),
        .rst       ( rst ),
        .cyc       ( cyc ),
        .stb       ( stb ),
        .we        ( we ),
        .adr       ( adr ),
        .dat_w     ( dat_w ),
        .ack       ( ack ),
        .status_rd ( status_rd ),
        .fifo      ( fifo_bus.master )
    );

    // Execute
    fifo_small #(
        .DEPTH ( DEPTH )
    ) i_fifo_small (
        .fifo  ( fifo_bus.fifo )
    );

    // Result
    mbox_result i_mbox_result (
        .clk       ( clk ),
        .rst       ( rst ),
        .status_rd ( status_rd ),
        .fifo      ( fifo_bus.monitor ),
        .dat_r     ( dat_r )
    );

endmodule : mbox_top

`default_nettype wire

// File: src/mbox_result.sv
// Result stage building the registered read word and holding sticky error flags
`default_nettype none

module mbox_result
    import mbox_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    status_rd,
    fifo_if.monitor fifo,
    output data_t   dat_r
);
    // --------------------------------------------------
    // Sticky error flags
    // --------------------------------------------------
    logic  sticky_oflow;
    logic  sticky_uflow;
    data_t status_word;

    // Set by a pulse, cleared by a status read
    // a pulse on the read edge itself wins
    always_ff @(posedge clk) begin
        if (rst) begin
            sticky_oflow <= 1'b0;
            sticky_uflow <= 1'b0;
        end else begin
            sticky_oflow <= (sticky_oflow && !status_rd) || fifo.oflow;
            sticky_uflow <= (sticky_uflow && !status_rd) || fifo.uflow;
        end
    end

    // --------------------------------------------------
    // Status word
    // --------------------------------------------------
    always_comb begin
        status_word                                      = '0;
        status_word[STAT_EMPTY_BIT]                      = fifo.empty;
        status_word[STAT_FULL_BIT]                       = fifo.full;
        status_word[STAT_OFLOW_BIT]                      = sticky_oflow;
        status_word[STAT_UFLOW_BIT]                      = sticky_uflow;
        status_word[STAT_COUNT_LSB +: STAT_COUNT_W]      = STAT_COUNT_W'(fifo.count);
    end

    // Read data register
    // Empty pop returns zero, held until the next read
    always_ff @(posedge clk) begin
        if (rst)
            dat_r <= '0;
        else if (fifo.pop)
            dat_r <= fifo.empty ? '0 : fifo.pop_data;
        else if (status_rd)
            dat_r <= status_word;
    end

endmodule : mbox_result

`default_nettype wire

// File: src/mbox_decode.sv
// Wishbone classic slave front end decoding bus cycles into FIFO strobes and ack
`default_nettype none

module mbox_decode
    import mbox_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // Wishbone classic slave
    input  logic   cyc,
    input  logic   stb,
    input  logic   we,
    input  addr_t  adr,
    input  data_t  dat_w,
    output logic   ack,

    // To result stage
    output logic   status_rd,

    // To FIFO
    fifo_if.master fifo
);
    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------
    logic req;

    // New request only while ack is low
    // keeps each cycle to one action
    assign req = cyc && stb && !ack;

    // Strobes are sampled on the edge that raises ack
    assign fifo.push      = req &&  we && (adr == ADDR_DATA);
    assign fifo.pop       = req && !we && (adr == ADDR_DATA);
    assign status_rd      = req && !we && (adr == ADDR_STATUS);
    assign fifo.push_data = dat_w;

    // Write to status address: acked, no effect

    // --------------------------------------------------
    // Acknowledge
    // --------------------------------------------------
    // Fixed single wait state
    always_ff @(posedge clk) begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= req;
    end

    // Single-clock ack per bus cycle
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack);

    // Never both directions in one cycle
    a_push_pop_excl: assert property (@(posedge clk) disable iff (rst)
        !(fifo.push && fifo.pop));

endmodule : mbox_decode

`default_nettype wire

// File: fifo/fifo_small.sv
// Small synchronous FIFO on distributed RAM with single-cycle write-to-read latency
`default_nettype none

module fifo_small
    import mbox_pkg::*;
#(
    parameter int DEPTH = 4
) (
    fifo_if.fifo fifo
);
    // --------------------------------------------------
    // Parameters and signals
    // --------------------------------------------------
    localparam int PTR_WID = DEPTH > 1 ? $clog2(DEPTH) : 1;

    // Storage, no reset so it maps to LUT RAM
    data_t              mem [DEPTH];

    logic               wr_safe;
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;

    // Control
    fifo_ctrl #(
        .DEPTH   ( DEPTH )
    ) i_fifo_ctrl (
        .clk     ( fifo.clk ),
        .rst     ( fifo.rst ),
        .wr      ( fifo.push ),
        .rd      ( fifo.pop ),
        .wr_safe ( wr_safe ),
        .wr_ptr  ( wr_ptr ),
        .rd_ptr  ( rd_ptr ),
        .count   ( fifo.count ),
        .full    ( fifo.full ),
        .empty   ( fifo.empty ),
        .oflow   ( fifo.oflow ),
        .uflow   ( fifo.uflow )
    );

    // Write port
    always_ff @(posedge fifo.clk) begin
        if (wr_safe)
            mem[wr_ptr] <= fifo.push_data;
    end

    // Asynchronous read, head word visible the cycle after it lands
    assign fifo.pop_data = mem[rd_ptr];

    // Write lands in a free slot, never on top of the unread head
    a_no_wr_full: assert property (@(posedge fifo.clk) disable iff (fifo.rst)
        wr_safe |-> fifo.empty || (wr_ptr != rd_ptr));

endmodule : fifo_small

`default_nettype wire

// File: fifo/fifo_ctrl.sv
// FIFO control with pointers, fill count, full/empty flags and over/underflow protection
`default_nettype none

module fifo_ctrl
    import mbox_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,

    // Requests from the FIFO user
    input  logic                                        wr,
    input  logic                                        rd,

    // Gated write enable and memory addresses
    output logic                                        wr_safe,
    output logic [(DEPTH > 1 ? $clog2(DEPTH) : 1)-1:0]  wr_ptr,
    output logic [(DEPTH > 1 ? $clog2(DEPTH) : 1)-1:0]  rd_ptr,

    // Status
    output logic [$clog2(DEPTH+1)-1:0]                  count,
    output logic                                        full,
    output logic                                        empty,
    output logic                                        oflow,
    output logic                                        uflow
);
    // --------------------------------------------------
    // Parameters
    // --------------------------------------------------
    localparam int PTR_WID = DEPTH > 1 ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH+1);

    // Depth must fit the status count field
    if (DEPTH < 1 || DEPTH > MAX_DEPTH) begin : g_depth_check
        $error("fifo_ctrl: DEPTH out of range");
    end

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    logic rd_safe;

    // Flags come straight off the registered count
    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);

    // Blocked requests never touch pointers or count
    assign wr_safe = wr && !full;
    assign rd_safe = rd && !empty;

    // One-cycle error pulses, same cycle as the request
    assign oflow = wr && full;
    assign uflow = rd && empty;

    // --------------------------------------------------
    // Pointers
    // --------------------------------------------------
    // Wrap at DEPTH-1 so any depth works, not only powers of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_safe) begin
            if (wr_ptr == PTR_WID'(DEPTH - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_safe) begin
            if (rd_ptr == PTR_WID'(DEPTH - 1))
                rd_ptr <= '0;
            else
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Fill count
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_safe, rd_safe})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or simultaneous
            endcase
        end
    end

    // Count bounded by depth across any request sequence
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_WID'(DEPTH));

endmodule : fifo_ctrl

`default_nettype wire

// File: common/fifo_if.sv
// FIFO interface bundling push and pop sides, flags and fill count
`default_nettype none

interface fifo_if
    import mbox_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic rst
);
    // Push side
    logic                         push;
    data_t                        push_data;
    logic                         full;
    logic                         oflow;

    // Pop side
    logic                         pop;
    data_t                        pop_data;
    logic                         empty;
    logic                         uflow;

    // Occupancy, wide enough to hold DEPTH itself
    logic [$clog2(DEPTH+1)-1:0]   count;

    // Bus front end drives the strobes
    modport master (input clk, rst, output push, push_data, pop);

    // Storage side answers with flags, data and count
    modport fifo (
        input  clk, rst, push, push_data, pop,
        output full, oflow, pop_data, empty, uflow, count
    );

    // Read-only tap for the result stage
    modport monitor (
        input clk, rst, push, push_data, full, oflow,
        input pop, pop_data, empty, uflow, count
    );

endinterface : fifo_if

`default_nettype wire

// File: common/mbox_pkg.sv
// Mailbox package with the word type, bus address codes and status word layout
`default_nettype none

package mbox_pkg;

    // --------------------------------------------------
    // Data word
    // --------------------------------------------------
    // One mailbox entry, also the width of the bus data
    typedef logic [15:0] data_t;

    // --------------------------------------------------
    // Bus address map
    // --------------------------------------------------
    typedef enum logic {
        ADDR_DATA   = 1'b0,  // push on write, pop on read
        ADDR_STATUS = 1'b1   // status word, read clears sticky flags
    } addr_t;

    // --------------------------------------------------
    // Status word fields
    // --------------------------------------------------
    // Live flags
    localparam int STAT_EMPTY_BIT = 0;
    localparam int STAT_FULL_BIT  = 1;

    // Sticky error flags
    localparam int STAT_OFLOW_BIT = 2;
    localparam int STAT_UFLOW_BIT = 3;

    // Fill count occupies the upper byte
    localparam int STAT_COUNT_LSB = 8;
    localparam int STAT_COUNT_W   = 8;

    // Deepest FIFO whose count still fits the count field
    localparam int MAX_DEPTH = 255;

endpackage : mbox_pkg

`default_nettype wire
